//--- display_subsystem.f
+incdir+src
src/display_pkg.sv
src/pixel_write_if.sv
src/frame_ram.sv
src/display_buffers.sv
src/pixel_drawer.sv
src/display_scanner.sv
src/display_subsystem.sv
sim/display_subsystem_tb.sv

//--- Bender.yml
package:
  name: display_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/display_pkg.sv
      - src/pixel_write_if.sv
      - src/frame_ram.sv
      - src/display_buffers.sv
      - src/pixel_drawer.sv
      - src/display_scanner.sv
      - src/display_subsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/display_subsystem_tb.sv

//--- sim/display_subsystem_tb.sv
// Testbench for the double-buffered display frame store
// Keeps a model of both buffers and checks every streamed pixel against it
`timescale 1ns/1ns
`include "display_consts.svh"

module display_subsystem_tb
    import display_pkg::*;
();

localparam int CLOCK_PERIOD = 100;
localparam int TEST_STEPS = 5;
localparam int FILL_COUNT = 2;
// Eight frames per test step plus the fills
localparam int TIMEOUT_CYCLES = (TEST_STEPS * 8 + FILL_COUNT) * `DISPLAY_PIXELS;
localparam int MIN_CHECKED_PIXELS = 16 * `DISPLAY_PIXELS;

logic clock_in;
logic reset_n_in;
logic command_valid;
draw_opcode_t command_opcode;
logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] command_address;
logic [`DISPLAY_PIXEL_BITS-1:0] command_color;
logic command_busy;
logic [`DISPLAY_PIXEL_BITS-1:0] pixel_out;
logic pixel_valid;
logic frame_start;

// Model of both buffers, model_shown picks the one on screen
logic [`DISPLAY_PIXEL_BITS-1:0] model_buffer [2][`DISPLAY_PIXELS] = '{default: '0};
logic model_shown = 1'b0;
int swaps_requested = 0;
int swaps_done = 0;
int checked_pixels = 0;
logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] pixel_position;
logic [`DISPLAY_PIXEL_BITS-1:0] expected_pixel;
logic [31:0] lfsr_state;

display_subsystem DUT (.*);

initial begin
    clock_in = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock_in = ~clock_in;
end

// A requested swap shows up from the next frame start on
assign expected_pixel = model_buffer[(frame_start && swaps_requested != swaps_done) ?
                                     !model_shown : model_shown][pixel_position];

always @(posedge clock_in) begin
    if (!reset_n_in) begin
        pixel_position <= '0;
    end else if (pixel_valid) begin
        pixel_position <= pixel_position + 1'b1;
        checked_pixels <= checked_pixels + 1;
        if (frame_start && swaps_requested != swaps_done) begin
            model_shown <= !model_shown;
            swaps_done <= swaps_done + 1;
        end
    end
end

// Frame start exactly once every full frame of valid pixels
assert property (@(posedge clock_in) disable iff (!reset_n_in)
    pixel_valid |-> frame_start == (pixel_position == '0))
    else begin
        $display("FAILED frame_start=%h expected=%h position=%h", $sampled(frame_start),
                 $sampled(pixel_position) == 0, $sampled(pixel_position));
        $display("Test FAILED");
        $fatal(1, "Frame start out of step with the pixel stream");
    end

assert property (@(posedge clock_in) disable iff (!reset_n_in)
    pixel_valid |-> pixel_out == expected_pixel)
    else begin
        $display("FAILED pixel_out=%h expected=%h position=%h", $sampled(pixel_out),
                 $sampled(expected_pixel), $sampled(pixel_position));
        $display("Test FAILED");
        $fatal(1, "Pixel stream differs from the model");
    end

// Galois LFSR, one step per random bit
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
endfunction

task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    repeat (count) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
endtask

task automatic wait_frame_start();
    @(negedge clock_in);
    while (!frame_start) begin
        @(negedge clock_in);
    end
endtask

task automatic wait_frames(input int count);
    repeat (count) wait_frame_start();
endtask

// Command stays on the inputs until released, so pixels can go back to back
task automatic drive_command(input draw_opcode_t opcode,
                             input logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] address,
                             input logic [`DISPLAY_PIXEL_BITS-1:0] color);
    @(negedge clock_in);
    while (command_busy) begin
        @(negedge clock_in);
    end
    command_valid = 1'b1;
    command_opcode = opcode;
    command_address = address;
    command_color = color;
    // Drawing always lands in the hidden buffer
    if (opcode == DRAW_PIXEL) begin
        model_buffer[!model_shown][address] = color;
    end else if (opcode == DRAW_FILL) begin
        for (int i = 0; i < `DISPLAY_PIXELS; i++) begin
            model_buffer[!model_shown][i] = color;
        end
    end else begin
        swaps_requested++;
    end
endtask

task automatic release_command();
    @(negedge clock_in);
    command_valid = 1'b0;
endtask

// Pixel strobes that the drawer must drop
task automatic strobe_while_busy(input int count);
    logic [31:0] value;
    repeat (count) begin
        @(negedge clock_in);
        if (!command_busy) begin
            $display("Drawer dropped busy while a command was still running");
            $display("Test FAILED");
            $fatal(1, "Busy ended early");
        end
        random_bits(13, value);
        command_valid = 1'b1;
        command_opcode = DRAW_PIXEL;
        command_address = value[12:4];
        command_color = value[3:0];
    end
    release_command();
endtask

task automatic fill_back_buffer(input logic [`DISPLAY_PIXEL_BITS-1:0] color);
    drive_command(DRAW_FILL, '0, color);
    strobe_while_busy(4);
    @(negedge clock_in);
    while (command_busy) begin
        @(negedge clock_in);
    end
endtask

// Request lands some cycles into a frame, the flip waits for the next one
task automatic swap_after(input int delay_cycles);
    wait_frame_start();
    repeat (delay_cycles) @(negedge clock_in);
    drive_command(DRAW_SWAP, '0, '0);
    strobe_while_busy(2);
    wait_frames(2);
endtask

initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock_in);
    $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $fatal(1, "Watchdog expired");
end

initial begin
    logic [31:0] value;
    logic [31:0] word_base;
    lfsr_state = 32'h6352_3a9e;
    reset_n_in = 1'b0;
    command_valid = 1'b0;
    command_opcode = DRAW_PIXEL;
    command_address = '0;
    command_color = '0;
    repeat (3) @(posedge clock_in);
    @(negedge clock_in);
    reset_n_in = 1'b1;

    // Blank frames after reset
    wait_frames(2);

    // Fill the hidden buffer, screen stays blank until the swap
    random_bits(4, value);
    fill_back_buffer(value[3:0] | 4'h1);
    wait_frames(1);
    swap_after(0);

    // Scattered pixels, then three writes into one word on back-to-back cycles
    repeat (16) begin
        random_bits(13, value);
        drive_command(DRAW_PIXEL, value[12:4], value[3:0]);
    end
    repeat (8) begin
        random_bits(9, word_base);
        repeat (3) begin
            random_bits(7, value);
            drive_command(DRAW_PIXEL, {word_base[8:3], value[6:4]}, value[3:0]);
        end
    end
    release_command();
    wait_frames(1);
    swap_after(100);

    // Swapping back and forth shows both buffers kept their content
    swap_after(0);
    swap_after(37);

    // Fresh fill with a request in the middle of a frame
    random_bits(4, value);
    fill_back_buffer(value[3:0] ^ 4'h8);
    random_bits(8, value);
    swap_after(value[7:0]);

    if (checked_pixels < MIN_CHECKED_PIXELS) begin
        $display("Only %0d pixels were checked", checked_pixels);
        $display("Test FAILED");
        $fatal(1, "Too few pixels checked");
    end else begin
        $display("Test OK");
        $finish;
    end
end

endmodule

//--- src/display_subsystem.sv
// Display frame store top level
// Drawer writes the back buffer while the scanner streams the shown one
`timescale 1ns/1ns
`include "display_consts.svh"

module display_subsystem import display_pkg::*; (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic command_valid,
    input  draw_opcode_t command_opcode,
    input  logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] command_address,
    input  logic [`DISPLAY_PIXEL_BITS-1:0] command_color,
    output logic command_busy,
    output logic [`DISPLAY_PIXEL_BITS-1:0] pixel_out,
    output logic pixel_valid,
    output logic frame_start
);

logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] read_address;
logic [`DISPLAY_PIXEL_BITS-1:0] read_data;

pixel_write_if pixel_writes ();

pixel_drawer drawer (
    .clock_in        (clock_in),
    .reset_n_in      (reset_n_in),
    .command_valid   (command_valid),
    .command_opcode  (command_opcode),
    .command_address (command_address),
    .command_color   (command_color),
    .command_busy    (command_busy),
    .write_port      (pixel_writes.drawer)
);

display_buffers buffers (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .write_port   (pixel_writes.buffers),
    .read_address (read_address),
    .read_data    (read_data)
);

display_scanner scanner (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .read_address (read_address),
    .read_data    (read_data),
    .pixel_out    (pixel_out),
    .pixel_valid  (pixel_valid),
    .frame_start  (frame_start)
);

endmodule

//--- src/display_scanner.sv
// Raster scanner for the shown buffer
// Free-running read addresses, valid and frame start aligned to the data
`timescale 1ns/1ns
`include "display_consts.svh"

module display_scanner (
    input  logic clock_in,
    input  logic reset_n_in,
    output logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] read_address,
    input  logic [`DISPLAY_PIXEL_BITS-1:0] read_data,
    output logic [`DISPLAY_PIXEL_BITS-1:0] pixel_out,
    output logic pixel_valid,
    output logic frame_start
);

// Matches the read latency of the frame buffers
localparam int PIPELINE_DEPTH = 3;

logic [PIPELINE_DEPTH-1:0] valid_delay;
logic [PIPELINE_DEPTH-1:0] frame_delay;

always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
        read_address <= '0;
        valid_delay <= '0;
        frame_delay <= '0;
    end else begin
        if (read_address == `DISPLAY_PIXELS - 1) begin
            read_address <= '0;
        end else begin
            read_address <= read_address + 1'b1;
        end

        valid_delay <= {valid_delay[PIPELINE_DEPTH-2:0], 1'b1};
        frame_delay <= {frame_delay[PIPELINE_DEPTH-2:0], read_address == '0};
    end
end

assign pixel_out = read_data;
assign pixel_valid = valid_delay[PIPELINE_DEPTH-1];
assign frame_start = frame_delay[PIPELINE_DEPTH-1];

endmodule

//--- src/pixel_drawer.sv
// Drawing command sequencer
// Turns single pixel, fill and swap commands into back buffer writes
`timescale 1ns/1ns
`include "display_consts.svh"

module pixel_drawer import display_pkg::*; (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic command_valid,
    input  draw_opcode_t command_opcode,
    input  logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] command_address,
    input  logic [`DISPLAY_PIXEL_BITS-1:0] command_color,
    output logic command_busy,
    pixel_write_if.drawer write_port
);

draw_state_t state;
logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] fill_counter;
logic [`DISPLAY_PIXEL_BITS-1:0] fill_color;
logic swap_hold;
logic command_accept;

// Strobes that arrive while busy are dropped
assign command_accept = command_valid && !command_busy;

always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
        state <= DRAW_IDLE;
        command_busy <= 1'b0;
        fill_counter <= '0;
        swap_hold <= 1'b0;
        write_port.write_enable <= 1'b0;
        write_port.switch_request <= 1'b0;
    end else begin
        write_port.write_enable <= 1'b0;
        case (state)
            DRAW_IDLE: begin
                command_busy <= 1'b0;
                if (command_accept) begin
                    case (command_opcode)
                        DRAW_PIXEL: begin
                            write_port.write_enable <= 1'b1;
                        end
                        DRAW_FILL: begin
                            state <= DRAW_FILLING;
                            command_busy <= 1'b1;
                            fill_counter <= '0;
                        end
                        DRAW_SWAP: begin
                            state <= DRAW_SWAPPING;
                            command_busy <= 1'b1;
                            swap_hold <= 1'b0;
                            write_port.switch_request <= 1'b1;
                        end
                        default: begin
                            command_busy <= 1'b0;
                        end
                    endcase
                end
            end

            // One write per cycle over the whole frame
            DRAW_FILLING: begin
                write_port.write_enable <= 1'b1;
                fill_counter <= fill_counter + 1'b1;
                if (fill_counter == `DISPLAY_PIXELS - 1) begin
                    state <= DRAW_IDLE;
                end
            end

            // Request held for two cycles
            DRAW_SWAPPING: begin
                swap_hold <= 1'b1;
                if (swap_hold) begin
                    state <= DRAW_IDLE;
                    command_busy <= 1'b0;
                    write_port.switch_request <= 1'b0;
                end
            end

            default: begin
                state <= DRAW_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clock_in) begin
    if (state == DRAW_FILLING) begin
        write_port.write_address <= fill_counter;
        write_port.write_data <= fill_color;
    end else if (command_accept) begin
        write_port.write_address <= command_address;
        write_port.write_data <= command_color;
        fill_color <= command_color;
    end
end

// Pixel writes never overlap a swap request
assert property (@(posedge clock_in) disable iff (!reset_n_in)
    write_port.switch_request |-> !write_port.write_enable)
    else $error("Pixel write issued during a swap request");

endmodule

//--- src/display_buffers.sv
// Double frame store made of two buffers of two word RAMs each
// Pixels are inserted by read-modify-write into the back buffer
// The shown buffer only flips when the scanner wraps to address 0
`timescale 1ns/1ns
`include "display_consts.svh"

module display_buffers import display_pkg::*; (
    input  logic clock_in,
    input  logic reset_n_in,
    pixel_write_if.buffers write_port,
    input  logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] read_address,
    output logic [`DISPLAY_PIXEL_BITS-1:0] read_data
);

localparam int HALF_BIT = `DISPLAY_PIXEL_ADDRESS_BITS - 1;
localparam int SELECT_BITS = HALF_BIT - `DISPLAY_WORD_ADDRESS_BITS;
localparam int KEY_BITS = `DISPLAY_WORD_ADDRESS_BITS + 1;
localparam int PB = `DISPLAY_PIXEL_BITS;

buffer_select_t displayed_buffer;
buffer_select_t back_buffer;
logic [1:0] switch_monitor;
logic switch_pending;

logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] read_address_reg;
buffer_select_t read_buffer;
logic read_half;
logic [SELECT_BITS-1:0] read_pixel;

logic write_valid_s1, write_valid_s2, write_valid_s3, write_valid_s4;
logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] write_address_s1, write_address_s2;
logic [PB-1:0] write_data_s1, write_data_s2;
// Half and word address of a write for spotting same-word writes
logic [KEY_BITS-1:0] write_key_s2, write_key_s3, write_key_s4;
logic [`DISPLAY_WORD_BITS-1:0] old_word, merged_word, merged_s3, merged_s4;

// Indexed [buffer][half] with half 0 as the top RAM
logic [1:0][1:0] ram_write_enable;
logic [1:0][`DISPLAY_WORD_ADDRESS_BITS-1:0] ram_read_address;
logic [1:0][1:0][`DISPLAY_WORD_BITS-1:0] ram_read_data;

assign back_buffer = buffer_select_t'(~displayed_buffer);
assign write_key_s2 = write_address_s2[HALF_BIT:SELECT_BITS];

always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
        displayed_buffer <= BUFFER_A;
        switch_monitor <= 2'b00;
        switch_pending <= 1'b0;
        write_valid_s1 <= 1'b0;
        write_valid_s2 <= 1'b0;
        write_valid_s3 <= 1'b0;
        write_valid_s4 <= 1'b0;
    end else begin
        switch_monitor <= {switch_monitor[0], write_port.switch_request};
        if (switch_monitor == 2'b01) begin
            switch_pending <= 1'b1;
        end

        // Flip only at frame start so a frame never tears
        if (switch_pending && read_address == '0) begin
            displayed_buffer <= back_buffer;
            switch_pending <= 1'b0;
        end

        write_valid_s1 <= write_port.write_enable;
        write_valid_s2 <= write_valid_s1;
        write_valid_s3 <= write_valid_s2;
        write_valid_s4 <= write_valid_s3;
    end
end

always_ff @(posedge clock_in) begin
    // Read path through address register, RAM and output register
    read_address_reg <= read_address;
    read_buffer <= displayed_buffer;
    read_half <= read_address_reg[HALF_BIT];
    read_pixel <= read_address_reg[SELECT_BITS-1:0];
    read_data <= ram_read_data[read_buffer][read_half][read_pixel*PB +: PB];

    write_address_s1 <= write_port.write_address;
    write_data_s1 <= write_port.write_data;
    write_address_s2 <= write_address_s1;
    write_data_s2 <= write_data_s1;
    write_key_s3 <= write_key_s2;
    merged_s3 <= merged_word;
    write_key_s4 <= write_key_s3;
    merged_s4 <= merged_s3;
end

// Old word comes from RAM unless a newer copy is still in flight
always_comb begin
    old_word = ram_read_data[back_buffer][write_key_s2[KEY_BITS-1]];
    if (write_valid_s3 && write_key_s3 == write_key_s2) begin
        old_word = merged_s3;
    end else if (write_valid_s4 && write_key_s4 == write_key_s2) begin
        // Written on the same edge as our read, so the RAM gave the stale word
        old_word = merged_s4;
    end
    merged_word = old_word;
    merged_word[write_address_s2[SELECT_BITS-1:0]*PB +: PB] = write_data_s2;
end

always_comb begin
    for (int b = 0; b < 2; b++) begin
        ram_read_address[b] = (b == displayed_buffer)
                            ? read_address_reg[HALF_BIT-1:SELECT_BITS]
                            : write_address_s1[HALF_BIT-1:SELECT_BITS];
        for (int h = 0; h < 2; h++) begin
            ram_write_enable[b][h] = write_valid_s3 && b != displayed_buffer &&
                                     h == write_key_s3[KEY_BITS-1];
        end
    end
end

frame_ram a_top (
    .clock_in      (clock_in),
    .write_enable  (ram_write_enable[BUFFER_A][0]),
    .write_address (write_key_s3[`DISPLAY_WORD_ADDRESS_BITS-1:0]),
    .write_data    (merged_s3),
    .read_address  (ram_read_address[BUFFER_A]),
    .read_data     (ram_read_data[BUFFER_A][0])
);

frame_ram a_bottom (
    .clock_in      (clock_in),
    .write_enable  (ram_write_enable[BUFFER_A][1]),
    .write_address (write_key_s3[`DISPLAY_WORD_ADDRESS_BITS-1:0]),
    .write_data    (merged_s3),
    .read_address  (ram_read_address[BUFFER_A]),
    .read_data     (ram_read_data[BUFFER_A][1])
);

frame_ram b_top (
    .clock_in      (clock_in),
    .write_enable  (ram_write_enable[BUFFER_B][0]),
    .write_address (write_key_s3[`DISPLAY_WORD_ADDRESS_BITS-1:0]),
    .write_data    (merged_s3),
    .read_address  (ram_read_address[BUFFER_B]),
    .read_data     (ram_read_data[BUFFER_B][0])
);

frame_ram b_bottom (
    .clock_in      (clock_in),
    .write_enable  (ram_write_enable[BUFFER_B][1]),
    .write_address (write_key_s3[`DISPLAY_WORD_ADDRESS_BITS-1:0]),
    .write_data    (merged_s3),
    .read_address  (ram_read_address[BUFFER_B]),
    .read_data     (ram_read_data[BUFFER_B][1])
);

// A second request while one is pending would merge into a single flip
assert property (@(posedge clock_in) disable iff (!reset_n_in)
    switch_monitor == 2'b01 |-> !switch_pending)
    else $error("Swap requested while another swap was still pending");

// Old word read and merged word written must hit the same buffer
assert property (@(posedge clock_in) disable iff (!reset_n_in)
    write_valid_s3 |-> displayed_buffer == $past(displayed_buffer, 2))
    else $error("Buffers swapped while a pixel write was in flight");

endmodule

//--- src/frame_ram.sv
// Word RAM holding one half of a frame buffer
// Synchronous read, read-first when read and write hit the same word
`timescale 1ns/1ns
`include "display_consts.svh"

module frame_ram (
    input  logic clock_in,
    input  logic write_enable,
    input  logic [`DISPLAY_WORD_ADDRESS_BITS-1:0] write_address,
    input  logic [`DISPLAY_WORD_BITS-1:0] write_data,
    input  logic [`DISPLAY_WORD_ADDRESS_BITS-1:0] read_address,
    output logic [`DISPLAY_WORD_BITS-1:0] read_data
);

localparam int DEPTH = 1 << `DISPLAY_WORD_ADDRESS_BITS;

// Frame starts out black
logic [`DISPLAY_WORD_BITS-1:0] memory [DEPTH] = '{default: '0};

always_ff @(posedge clock_in) begin
    if (write_enable) begin
        memory[write_address] <= write_data;
    end
    read_data <= memory[read_address];
end

endmodule

//--- src/pixel_write_if.sv
// Pixel write link from the drawer to the frame buffers
// Also carries the buffer swap request
`timescale 1ns/1ns
`include "display_consts.svh"

interface pixel_write_if;

logic write_enable;
logic [`DISPLAY_PIXEL_ADDRESS_BITS-1:0] write_address;
logic [`DISPLAY_PIXEL_BITS-1:0] write_data;

// Level, a rising edge asks for a swap
logic switch_request;

modport drawer (
    output write_enable, write_address, write_data, switch_request
);

modport buffers (
    input write_enable, write_address, write_data, switch_request
);

endinterface

//--- src/display_pkg.sv
// Shared types for the double-buffered display frame store
// Buffer selection, drawing opcodes and drawer states
package display_pkg;

// Buffer that the scanner is currently showing
typedef enum logic {
    BUFFER_A,
    BUFFER_B
} buffer_select_t;

// Commands accepted by the pixel drawer
typedef enum logic [1:0] {
    DRAW_PIXEL,
    DRAW_FILL,
    DRAW_SWAP
} draw_opcode_t;

// Drawer sequencing
typedef enum logic [1:0] {
    DRAW_IDLE,
    DRAW_FILLING,
    DRAW_SWAPPING
} draw_state_t;

endpackage

//--- src/display_consts.svh
// Frame geometry and address widths of the display frame store
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// Reduced frame size
`define DISPLAY_WIDTH 32
`define DISPLAY_HEIGHT 16
`define DISPLAY_PIXELS (`DISPLAY_WIDTH * `DISPLAY_HEIGHT)

// Pixel address is {half, word address, pixel in word}
`define DISPLAY_PIXEL_ADDRESS_BITS 9
`define DISPLAY_PIXEL_BITS 4

// Eight pixels per RAM word
`define DISPLAY_WORD_BITS 32
`define DISPLAY_WORD_ADDRESS_BITS 5

`endif
